/* design/axil_macros.svh */
`ifndef AXIL_MACROS_SVH
`define AXIL_MACROS_SVH

// bus widths
`define AXIL_ADDR_W 8
`define AXIL_DATA_W 32
`define AXIL_STRB_W (`AXIL_DATA_W / 8)
`define AXIL_ID_W 4

// stall probability, compared against an equally wide random draw
`define AXIL_PROB_W 8

`define AXIL_REG_WORDS 32  // slave register file depth

`endif

/* design/axil_pkg.sv */
`include "axil_macros.svh"

package axil_pkg;

  typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;  // byte address
  typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [`AXIL_STRB_W-1:0] axil_strb_t;  // one bit per data byte
  typedef logic [`AXIL_ID_W-1:0] axil_id_t;

  // 0 never stalls, larger values stall more often
  typedef logic [`AXIL_PROB_W-1:0] axil_prob_t;

  // only OKAY and SLVERR come out of the slave
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

endpackage

/* design/prng_pkg.sv */
package prng_pkg;

  // one state half, also the width of each result
  typedef logic [63:0] prng_word_t;

  // fixed seeds so every run replays the same traffic
  localparam prng_word_t PRNG_SEED_S0 = 64'd1414213562;  // sqrt 2
  localparam prng_word_t PRNG_SEED_S1 = 64'd2718281828;  // e

endpackage

/* design/axil_if.sv */
`timescale 1ns/1ps

interface axil_if import axil_pkg::*; ();

  axil_id_t   aw_id;
  axil_addr_t aw_addr;
  logic       aw_valid;
  logic       aw_ready;

  axil_data_t w_data;
  axil_strb_t w_strb;
  logic       w_valid;
  logic       w_ready;

  axil_id_t   b_id;
  axil_resp_e b_resp;
  logic       b_valid;
  logic       b_ready;

  axil_id_t   ar_id;
  axil_addr_t ar_addr;
  logic       ar_valid;
  logic       ar_ready;

  axil_id_t   r_id;
  axil_data_t r_data;
  axil_resp_e r_resp;
  logic       r_valid;
  logic       r_ready;

  modport master (
    output aw_id, aw_addr, aw_valid, w_data, w_strb, w_valid, ar_id, ar_addr, ar_valid,
    output b_ready, r_ready,
    input  aw_ready, w_ready, ar_ready,
    input  b_id, b_resp, b_valid, r_id, r_data, r_resp, r_valid
  );

  modport slave (
    input  aw_id, aw_addr, aw_valid, w_data, w_strb, w_valid, ar_id, ar_addr, ar_valid,
    input  b_ready, r_ready,
    output aw_ready, w_ready, ar_ready,
    output b_id, b_resp, b_valid, r_id, r_data, r_resp, r_valid
  );

endinterface

/* design/prng_xoroshiro128p.sv */
`timescale 1ns/1ps

module prng_xoroshiro128p import prng_pkg::*; (
  input  logic       i_clk,
  input  logic       i_reset,
  output prng_word_t o_result
);

  prng_word_t s0_q;
  prng_word_t s1_q;
  prng_word_t s_mix;  // s0 ^ s1, feeds both updates
  logic       seed_q;  // reset was high last cycle

  assign o_result = s0_q + s1_q;
  assign s_mix = s0_q ^ s1_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      seed_q <= 1'b1;
    end else begin
      seed_q <= 1'b0;
    end
  end

  // seeds are (re)loaded while the flag is up, which covers the
  // first cycle after reset drops
  always_ff @(posedge i_clk) begin
    if (seed_q) begin
      s0_q <= PRNG_SEED_S0;
      s1_q <= PRNG_SEED_S1;
    end else begin
      s0_q <= {s0_q[39:0], s0_q[63:40]} ^ s_mix ^ (s_mix << 16);  // rotl 24
      s1_q <= {s_mix[26:0], s_mix[63:27]};  // rotl 37
    end
  end

endmodule

/* design/fifo_w1r1.sv */
`timescale 1ns/1ps

module fifo_w1r1 #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_valid,
  output logic             o_ready,
  output logic [WIDTH-1:0] o_data,
  output logic             o_valid,
  input  logic             i_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;  // wrap
    end
    return ptr + 1'b1;
  endfunction

  assign o_ready = (count_q != CNT_W'(DEPTH));  // not full
  assign o_valid = (count_q != '0);
  assign o_data = mem[rd_ptr_q];
  assign push = i_valid && o_ready;
  assign pop = o_valid && i_ready;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) mem[wr_ptr_q] <= i_data;
  end

  count_bound_a: assert property (@(posedge i_clk) disable iff (i_reset)
    count_q <= CNT_W'(DEPTH))
    else $error("fifo count above depth");

endmodule

/* design/axil_random_master.sv */
`timescale 1ns/1ps

module axil_random_master
  import axil_pkg::*;
  import prng_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  input  axil_prob_t i_pr_aw_stall,
  input  axil_prob_t i_pr_w_stall,
  input  axil_prob_t i_pr_b_stall,
  input  axil_prob_t i_pr_ar_stall,
  input  axil_prob_t i_pr_r_stall,
  axil_if.master     bus
);

  localparam int AW_W = $bits(axil_id_t) + $bits(axil_addr_t);
  localparam int W_W = $bits(axil_data_t) + $bits(axil_strb_t);
  localparam int PW = $bits(axil_prob_t);

  prng_word_t rnd;

  // stall draws from the low 40 bits
  axil_prob_t rnd_aw_stall;
  axil_prob_t rnd_w_stall;
  axil_prob_t rnd_b_stall;
  axil_prob_t rnd_ar_stall;
  axil_prob_t rnd_r_stall;

  // payload fields, overlap with the draws is harmless
  axil_id_t   rnd_aw_id;
  axil_addr_t rnd_aw_addr;
  axil_data_t rnd_w_data;
  axil_strb_t rnd_w_strb;
  axil_id_t   rnd_ar_id;
  axil_addr_t rnd_ar_addr;

  logic            aw_room;
  logic            w_room;
  logic            ar_room;
  logic            wr_push;
  logic [AW_W-1:0] aw_head;
  logic [W_W-1:0]  w_head;
  logic [AW_W-1:0] ar_head;
  logic            aw_head_valid;
  logic            w_head_valid;
  logic            ar_head_valid;
  logic            aw_keep_q;
  logic            w_keep_q;
  logic            ar_keep_q;

  prng_xoroshiro128p prng_inst (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .o_result (rnd)
  );

  assign rnd_aw_stall = rnd[0*PW +: PW];
  assign rnd_w_stall = rnd[1*PW +: PW];
  assign rnd_b_stall = rnd[2*PW +: PW];
  assign rnd_ar_stall = rnd[3*PW +: PW];
  assign rnd_r_stall = rnd[4*PW +: PW];

  assign rnd_aw_id = rnd[40 +: $bits(axil_id_t)];
  assign rnd_ar_id = rnd[44 +: $bits(axil_id_t)];
  assign rnd_aw_addr = rnd[48 +: $bits(axil_addr_t)];
  assign rnd_ar_addr = rnd[56 +: $bits(axil_addr_t)];
  assign rnd_w_data = rnd[24 +: $bits(axil_data_t)];
  assign rnd_w_strb = rnd[60 +: $bits(axil_strb_t)];

  // AW and W only ever pushed as a pair, keeps them in step
  assign wr_push = aw_room && w_room;

  fifo_w1r1 #(.WIDTH(AW_W), .DEPTH(2)) aw_fifo_inst (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_data  ({rnd_aw_id, rnd_aw_addr}),
    .i_valid (wr_push),
    .o_ready (aw_room),
    .o_data  (aw_head),
    .o_valid (aw_head_valid),
    .i_ready (bus.aw_valid && bus.aw_ready)
  );

  fifo_w1r1 #(.WIDTH(W_W), .DEPTH(2)) w_fifo_inst (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_data  ({rnd_w_data, rnd_w_strb}),
    .i_valid (wr_push),
    .o_ready (w_room),
    .o_data  (w_head),
    .o_valid (w_head_valid),
    .i_ready (bus.w_valid && bus.w_ready)
  );

  fifo_w1r1 #(.WIDTH(AW_W), .DEPTH(2)) ar_fifo_inst (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_data  ({rnd_ar_id, rnd_ar_addr}),
    .i_valid (ar_room),  // always try to queue another read
    .o_ready (ar_room),
    .o_data  (ar_head),
    .o_valid (ar_head_valid),
    .i_ready (bus.ar_valid && bus.ar_ready)
  );

  assign {bus.aw_id, bus.aw_addr} = aw_head;
  assign {bus.w_data, bus.w_strb} = w_head;
  assign {bus.ar_id, bus.ar_addr} = ar_head;

  // a shown valid is kept up by the keep flag until it transfers
  assign bus.aw_valid = aw_head_valid && (!(i_pr_aw_stall > rnd_aw_stall) || aw_keep_q);
  assign bus.w_valid = w_head_valid && (!(i_pr_w_stall > rnd_w_stall) || w_keep_q);
  assign bus.ar_valid = ar_head_valid && (!(i_pr_ar_stall > rnd_ar_stall) || ar_keep_q);

  assign bus.b_ready = !(i_pr_b_stall > rnd_b_stall);
  assign bus.r_ready = !(i_pr_r_stall > rnd_r_stall);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      aw_keep_q <= 1'b0;
      w_keep_q <= 1'b0;
      ar_keep_q <= 1'b0;
    end else begin
      aw_keep_q <= bus.aw_valid && !bus.aw_ready;
      w_keep_q <= bus.w_valid && !bus.w_ready;
      ar_keep_q <= bus.ar_valid && !bus.ar_ready;
    end
  end

  aw_hold_a: assert property (@(posedge i_clk) disable iff (i_reset)
    bus.aw_valid && !bus.aw_ready |=> bus.aw_valid && $stable({bus.aw_id, bus.aw_addr}))
    else $error("AW dropped or changed before handshake");

  w_hold_a: assert property (@(posedge i_clk) disable iff (i_reset)
    bus.w_valid && !bus.w_ready |=> bus.w_valid && $stable({bus.w_data, bus.w_strb}))
    else $error("W dropped or changed before handshake");

  ar_hold_a: assert property (@(posedge i_clk) disable iff (i_reset)
    bus.ar_valid && !bus.ar_ready |=> bus.ar_valid && $stable({bus.ar_id, bus.ar_addr}))
    else $error("AR dropped or changed before handshake");

endmodule

/* design/axil_reg_slave.sv */
`timescale 1ns/1ps
`include "axil_macros.svh"

module axil_reg_slave import axil_pkg::*; (
  input logic   i_clk,
  input logic   i_reset,
  axil_if.slave bus
);

  localparam int IDX_W = $clog2(`AXIL_REG_WORDS);

  axil_data_t       regs [`AXIL_REG_WORDS];
  logic             wr_fire;
  logic             rd_fire;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             wr_err;  // upper half of address space
  logic             rd_err;

  logic       b_valid_q;
  axil_id_t   b_id_q;
  axil_resp_e b_resp_q;
  logic       r_valid_q;
  axil_id_t   r_id_q;
  axil_data_t r_data_q;
  axil_resp_e r_resp_q;

  assign wr_idx = bus.aw_addr[IDX_W+1:2];  // word index
  assign rd_idx = bus.ar_addr[IDX_W+1:2];
  assign wr_err = bus.aw_addr[`AXIL_ADDR_W-1];
  assign rd_err = bus.ar_addr[`AXIL_ADDR_W-1];

  // AW and W taken together, one B outstanding at most
  assign bus.aw_ready = bus.w_valid && !b_valid_q;
  assign bus.w_ready = bus.aw_valid && !b_valid_q;
  assign bus.ar_ready = !r_valid_q;
  assign wr_fire = bus.aw_valid && bus.w_valid && !b_valid_q;
  assign rd_fire = bus.ar_valid && bus.ar_ready;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < `AXIL_REG_WORDS; i++) regs[i] <= '0;
    end else if (wr_fire && !wr_err) begin
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
        if (bus.w_strb[b]) regs[wr_idx][8*b +: 8] <= bus.w_data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_fire) b_valid_q <= 1'b1;
      else if (bus.b_ready) b_valid_q <= 1'b0;
      if (rd_fire) r_valid_q <= 1'b1;
      else if (bus.r_ready) r_valid_q <= 1'b0;
    end
  end

  // read data sampled before this edge's write lands
  always_ff @(posedge i_clk) begin
    if (wr_fire) begin
      b_id_q <= bus.aw_id;
      b_resp_q <= wr_err ? SLVERR : OKAY;
    end
    if (rd_fire) begin
      r_id_q <= bus.ar_id;
      r_data_q <= rd_err ? '0 : regs[rd_idx];
      r_resp_q <= rd_err ? SLVERR : OKAY;
    end
  end

  assign bus.b_valid = b_valid_q;
  assign bus.b_id = b_id_q;
  assign bus.b_resp = b_resp_q;
  assign bus.r_valid = r_valid_q;
  assign bus.r_id = r_id_q;
  assign bus.r_data = r_data_q;
  assign bus.r_resp = r_resp_q;

  b_hold_a: assert property (@(posedge i_clk) disable iff (i_reset)
    bus.b_valid && !bus.b_ready |=> bus.b_valid)
    else $error("B valid dropped before handshake");

  r_hold_a: assert property (@(posedge i_clk) disable iff (i_reset)
    bus.r_valid && !bus.r_ready |=> bus.r_valid)
    else $error("R valid dropped before handshake");

endmodule

/* design/axil_stress_top.sv */
`timescale 1ns/1ps
`include "axil_macros.svh"

module axil_stress_top (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic [`AXIL_PROB_W-1:0] i_pr_aw_stall,
  input  logic [`AXIL_PROB_W-1:0] i_pr_w_stall,
  input  logic [`AXIL_PROB_W-1:0] i_pr_b_stall,
  input  logic [`AXIL_PROB_W-1:0] i_pr_ar_stall,
  input  logic [`AXIL_PROB_W-1:0] i_pr_r_stall,
  output logic                    o_aw_valid,
  output logic                    o_aw_ready,
  output logic [`AXIL_ID_W-1:0]   o_aw_id,
  output logic [`AXIL_ADDR_W-1:0] o_aw_addr,
  output logic                    o_w_valid,
  output logic                    o_w_ready,
  output logic [`AXIL_DATA_W-1:0] o_w_data,
  output logic [`AXIL_STRB_W-1:0] o_w_strb,
  output logic                    o_b_valid,
  output logic                    o_b_ready,
  output logic [`AXIL_ID_W-1:0]   o_b_id,
  output logic [1:0]              o_b_resp,
  output logic                    o_ar_valid,
  output logic                    o_ar_ready,
  output logic [`AXIL_ID_W-1:0]   o_ar_id,
  output logic [`AXIL_ADDR_W-1:0] o_ar_addr,
  output logic                    o_r_valid,
  output logic                    o_r_ready,
  output logic [`AXIL_ID_W-1:0]   o_r_id,
  output logic [`AXIL_DATA_W-1:0] o_r_data,
  output logic [1:0]              o_r_resp
);

  axil_if axil_bus ();

  axil_random_master axil_random_master_inst (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_pr_aw_stall (i_pr_aw_stall),
    .i_pr_w_stall  (i_pr_w_stall),
    .i_pr_b_stall  (i_pr_b_stall),
    .i_pr_ar_stall (i_pr_ar_stall),
    .i_pr_r_stall  (i_pr_r_stall),
    .bus           (axil_bus.master)
  );

  axil_reg_slave axil_reg_slave_inst (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .bus     (axil_bus.slave)
  );

  // monitor taps for the testbench memory model
  assign o_aw_valid = axil_bus.aw_valid;
  assign o_aw_ready = axil_bus.aw_ready;
  assign o_aw_id = axil_bus.aw_id;
  assign o_aw_addr = axil_bus.aw_addr;
  assign o_w_valid = axil_bus.w_valid;
  assign o_w_ready = axil_bus.w_ready;
  assign o_w_data = axil_bus.w_data;
  assign o_w_strb = axil_bus.w_strb;
  assign o_b_valid = axil_bus.b_valid;
  assign o_b_ready = axil_bus.b_ready;
  assign o_b_id = axil_bus.b_id;
  assign o_b_resp = axil_bus.b_resp;
  assign o_ar_valid = axil_bus.ar_valid;
  assign o_ar_ready = axil_bus.ar_ready;
  assign o_ar_id = axil_bus.ar_id;
  assign o_ar_addr = axil_bus.ar_addr;
  assign o_r_valid = axil_bus.r_valid;
  assign o_r_ready = axil_bus.r_ready;
  assign o_r_id = axil_bus.r_id;
  assign o_r_data = axil_bus.r_data;
  assign o_r_resp = axil_bus.r_resp;

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;  // 8 ns period
  end

  // held for four rising edges, released right after the fourth
  initial begin
    o_reset = 1'b1;
    repeat (4) @(posedge o_clk);
    o_reset <= 1'b0;
  end

endmodule

/* tb/axil_stress_tb.sv */
`timescale 1ns/1ps
`include "axil_macros.svh"

module axil_stress_tb import axil_pkg::*; ();

  typedef struct packed {
    axil_id_t   id;
    axil_resp_e resp;
  } b_item_t;

  typedef struct packed {
    axil_id_t   id;
    axil_data_t data;
    axil_resp_e resp;
  } r_item_t;

  logic       clk;
  logic       reset;
  axil_prob_t pr_aw;
  axil_prob_t pr_w;
  axil_prob_t pr_b;
  axil_prob_t pr_ar;
  axil_prob_t pr_r;

  logic       aw_valid, aw_ready;
  axil_id_t   aw_id;
  axil_addr_t aw_addr;
  logic       w_valid, w_ready;
  axil_data_t w_data;
  axil_strb_t w_strb;
  logic       b_valid, b_ready;
  axil_id_t   b_id;
  logic [1:0] b_resp;
  logic       ar_valid, ar_ready;
  axil_id_t   ar_id;
  axil_addr_t ar_addr;
  logic       r_valid, r_ready;
  axil_id_t   r_id;
  axil_data_t r_data;
  logic [1:0] r_resp;

  axil_data_t model_mem [`AXIL_REG_WORDS];
  b_item_t    exp_b_q[$];
  r_item_t    exp_r_q[$];
  b_item_t    got_b_q[$];  // monitor responses waiting for compare
  r_item_t    got_r_q[$];
  logic       model_idle = 1'b1;

  int errors = 0;
  int checks = 0;
  int writes_done = 0;
  int reads_done = 0;
  int holds_seen = 0;
  int partial_writes = 0;
  int slverr_reads = 0;

  // request channels waiting on ready at the last edge
  logic        aw_pend, w_pend, ar_pend;
  logic [39:0] aw_prev, w_prev, ar_prev;

  tb_clock_gen clock_gen_inst (
    .o_clk   (clk),
    .o_reset (reset)
  );

  axil_stress_top axil_stress_top_inst (
    .i_clk (clk), .i_reset (reset),
    .i_pr_aw_stall (pr_aw), .i_pr_w_stall (pr_w), .i_pr_b_stall (pr_b),
    .i_pr_ar_stall (pr_ar), .i_pr_r_stall (pr_r),
    .o_aw_valid (aw_valid), .o_aw_ready (aw_ready), .o_aw_id (aw_id), .o_aw_addr (aw_addr),
    .o_w_valid (w_valid), .o_w_ready (w_ready), .o_w_data (w_data), .o_w_strb (w_strb),
    .o_b_valid (b_valid), .o_b_ready (b_ready), .o_b_id (b_id), .o_b_resp (b_resp),
    .o_ar_valid (ar_valid), .o_ar_ready (ar_ready), .o_ar_id (ar_id), .o_ar_addr (ar_addr),
    .o_r_valid (r_valid), .o_r_ready (r_ready), .o_r_id (r_id), .o_r_data (r_data),
    .o_r_resp (r_resp)
  );

  // expected slave answer for one address
  function automatic axil_data_t mem_model_read(input axil_addr_t addr,
                                                output axil_resp_e resp);
    if (addr[`AXIL_ADDR_W-1]) begin
      resp = SLVERR;  // upper half reads as zero
      return '0;
    end
    resp = OKAY;
    return model_mem[addr[6:2]];
  endfunction

  function automatic void mem_model_write(input axil_addr_t addr, input axil_data_t data,
                                          input axil_strb_t strb);
    if (addr[`AXIL_ADDR_W-1]) return;  // dropped by the slave
    for (int b = 0; b < `AXIL_STRB_W; b++) begin
      if (strb[b]) model_mem[addr[6:2]][8*b +: 8] = data[8*b +: 8];
    end
  endfunction

  task automatic check_b(input axil_id_t exp_id, input axil_resp_e exp_resp,
                         input axil_id_t got_id, input axil_resp_e got_resp);
    checks++;
    if (got_id !== exp_id) begin
      errors++;
      $display("MISMATCH o_b_id expected %h got %h", exp_id, got_id);
    end
    if (got_resp !== exp_resp) begin
      errors++;
      $display("MISMATCH o_b_resp expected %h got %h", exp_resp, got_resp);
    end
  endtask

  task automatic check_r(input axil_id_t exp_id, input axil_data_t exp_data,
                         input axil_resp_e exp_resp, input axil_id_t got_id,
                         input axil_data_t got_data, input axil_resp_e got_resp);
    checks++;
    if (got_id !== exp_id) begin
      errors++;
      $display("MISMATCH o_r_id expected %h got %h", exp_id, got_id);
    end
    if (got_data !== exp_data) begin
      errors++;
      $display("MISMATCH o_r_data expected %h got %h", exp_data, got_data);
    end
    if (got_resp !== exp_resp) begin
      errors++;
      $display("MISMATCH o_r_resp expected %h got %h", exp_resp, got_resp);
    end
  endtask

  task automatic check_hold(input string name, input logic pend, input logic valid,
                            input logic [39:0] prev, input logic [39:0] now);
    if (!pend) return;
    holds_seen++;
    checks++;
    if (valid !== 1'b1) begin
      errors++;
      $display("%s valid was dropped before its handshake", name);
    end else if (now !== prev) begin
      errors++;
      $display("MISMATCH %s payload expected %h got %h", name, prev, now);
    end
  endtask

  task automatic check_quiet();
    checks++;
    if ({aw_valid, w_valid, b_valid, ar_valid, r_valid} !== 5'h0) begin
      errors++;
      $display("MISMATCH o_{aw,w,b,ar,r}_valid expected %h got %h", 5'h0,
               {aw_valid, w_valid, b_valid, ar_valid, r_valid});
    end
  endtask

  task automatic set_probs(input axil_prob_t aw, input axil_prob_t w, input axil_prob_t b,
                           input axil_prob_t ar, input axil_prob_t r);
    @(negedge clk);
    pr_aw = aw;
    pr_w = w;
    pr_b = b;
    pr_ar = ar;
    pr_r = r;
  endtask

  task automatic wait_traffic(input int n_wr, input int n_rd, input int max_cycles,
                              input logic ready_high);
    int wr0;
    int rd0;
    int cyc;
    wr0 = writes_done;
    rd0 = reads_done;
    cyc = 0;
    while ((writes_done - wr0 < n_wr || reads_done - rd0 < n_rd) && cyc < max_cycles) begin
      @(posedge clk);
      if (ready_high && b_ready !== 1'b1) begin
        errors++;
        $display("MISMATCH o_b_ready expected %h got %h", 1'b1, b_ready);
      end
      if (ready_high && r_ready !== 1'b1) begin
        errors++;
        $display("MISMATCH o_r_ready expected %h got %h", 1'b1, r_ready);
      end
      cyc++;
    end
    if (writes_done - wr0 < n_wr || reads_done - rd0 < n_rd) begin
      errors++;
      $display("timeout after %0d cycles, only %0d writes and %0d reads completed",
               max_cycles, writes_done - wr0, reads_done - rd0);
    end
  endtask

  task automatic wait_drain(input int max_cycles);
    int cyc;
    cyc = 0;
    while (!model_idle && cyc < max_cycles) begin
      @(posedge clk);
      cyc++;
    end
    if (!model_idle) begin
      errors++;
      $display("timeout, expected responses still outstanding after %0d cycles", max_cycles);
    end
  endtask

  task automatic end_test(input int num, input string name, input int err0);
    $display("test %0d %s: %s, %0d errors", num, name,
             (errors == err0) ? "ok" : "bad", errors - err0);
  endtask

  // monitor and model update on the values from before the edge
  always @(posedge clk) begin
    b_item_t    bi;
    r_item_t    ri;
    axil_resp_e rr;
    if (reset) begin
      foreach (model_mem[i]) model_mem[i] = '0;
      aw_pend = 1'b0;
      w_pend = 1'b0;
      ar_pend = 1'b0;
    end else begin
      if (b_valid && b_ready) begin
        bi.id = b_id;
        bi.resp = axil_resp_e'(b_resp);
        got_b_q.push_back(bi);
      end
      if (r_valid && r_ready) begin
        ri.id = r_id;
        ri.data = r_data;
        ri.resp = axil_resp_e'(r_resp);
        got_r_q.push_back(ri);
      end
      // read goes ahead of this edge's write
      if (ar_valid && ar_ready) begin
        ri.id = ar_id;
        ri.data = mem_model_read(ar_addr, rr);
        ri.resp = rr;
        exp_r_q.push_back(ri);
      end
      if ((aw_valid && aw_ready) !== (w_valid && w_ready)) begin
        errors++;
        $display("AW and W handshakes did not happen in the same cycle");
      end
      if (aw_valid && aw_ready) begin
        void'(mem_model_read(aw_addr, rr));
        bi.id = aw_id;
        bi.resp = rr;
        exp_b_q.push_back(bi);
        mem_model_write(aw_addr, w_data, w_strb);
        if (w_strb != '0 && w_strb != '1) partial_writes++;
      end
      check_hold("o_aw", aw_pend, aw_valid, aw_prev, 40'({aw_id, aw_addr}));
      check_hold("o_w", w_pend, w_valid, w_prev, 40'({w_data, w_strb}));
      check_hold("o_ar", ar_pend, ar_valid, ar_prev, 40'({ar_id, ar_addr}));
      aw_pend = aw_valid && !aw_ready;
      w_pend = w_valid && !w_ready;
      ar_pend = ar_valid && !ar_ready;
      aw_prev = 40'({aw_id, aw_addr});
      w_prev = 40'({w_data, w_strb});
      ar_prev = 40'({ar_id, ar_addr});
    end
  end

  // compare half a cycle after the monitor
  always @(negedge clk) begin
    b_item_t eb;
    b_item_t gb;
    r_item_t er;
    r_item_t gr;
    while (got_b_q.size() > 0) begin
      gb = got_b_q.pop_front();
      if (exp_b_q.size() == 0) begin
        errors++;
        $display("B response with id %h arrived with no write outstanding", gb.id);
      end else begin
        eb = exp_b_q.pop_front();
        check_b(eb.id, eb.resp, gb.id, gb.resp);
        writes_done++;
      end
    end
    while (got_r_q.size() > 0) begin
      gr = got_r_q.pop_front();
      if (exp_r_q.size() == 0) begin
        errors++;
        $display("R response with id %h arrived with no read outstanding", gr.id);
      end else begin
        er = exp_r_q.pop_front();
        check_r(er.id, er.data, er.resp, gr.id, gr.data, gr.resp);
        if (er.resp == SLVERR) slverr_reads++;
        reads_done++;
      end
    end
    model_idle = (exp_b_q.size() == 0) && (exp_r_q.size() == 0);
  end

  initial begin
    int err0;
    int cyc;
    int holds0;
    pr_aw = '0;
    pr_w = '0;
    pr_b = '0;
    pr_ar = '0;
    pr_r = '0;
    void'($urandom(10));

    // no valids during reset and the cycle after
    err0 = errors;
    cyc = 0;
    do begin
      @(negedge clk);
      check_quiet();
      cyc++;
    end while (reset && cyc < 20);
    if (reset) begin
      errors++;
      $display("timeout, reset was never released");
    end
    end_test(1, "quiet valids around reset", err0);

    // free running traffic
    err0 = errors;
    wait_traffic(50, 50, 2000, 1'b1);
    end_test(2, "zero stall write responses", err0);

    // random stall mix per phase
    err0 = errors;
    for (int ph = 0; ph < 3; ph++) begin
      set_probs(axil_prob_t'($urandom_range(0, 200)), axil_prob_t'($urandom_range(0, 200)),
                axil_prob_t'($urandom_range(0, 200)), axil_prob_t'($urandom_range(0, 200)),
                axil_prob_t'($urandom_range(0, 200)));
      wait_traffic(20, 20, 20000, 1'b0);
    end
    if (partial_writes == 0 || slverr_reads == 0) begin
      errors++;
      $display("no partial write or no SLVERR read was exercised");
    end
    end_test(3, "read data, strobes and SLVERR", err0);

    // heavy request stalls
    err0 = errors;
    holds0 = holds_seen;
    set_probs(8'd230, 8'd230, axil_prob_t'($urandom_range(0, 64)), 8'd230,
              axil_prob_t'($urandom_range(0, 64)));
    wait_traffic(10, 10, 20000, 1'b0);
    if (holds_seen == holds0) begin
      errors++;
      $display("no request was ever held waiting for ready");
    end
    end_test(4, "valid and payload held until handshake", err0);

    // everything stalls almost always
    err0 = errors;
    set_probs('1, '1, '1, '1, '1);
    wait_traffic(5, 5, 100000, 1'b0);
    set_probs('1, '1, '0, '1, '0);  // starve requests while responses drain
    wait_drain(20000);
    end_test(5, "maximum stall progress and drain", err0);

    $display("summary: %0d checks, %0d errors, %0d writes, %0d reads", checks, errors,
             writes_done, reads_done);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+design
design/axil_pkg.sv
design/prng_pkg.sv
design/axil_if.sv
design/prng_xoroshiro128p.sv
design/fifo_w1r1.sv
design/axil_random_master.sv
design/axil_reg_slave.sv
design/axil_stress_top.sv
tb/tb_clock_gen.sv
tb/axil_stress_tb.sv
